// ==== build.f ====
corr_pkg.sv
vis_correlator.sv
vis_bank_ram.sv
vis_readback.sv
corr_block.sv
tb_corr_block.sv

// ==== Bender.yml ====
package:
  name: corr_block

sources:
  - corr_pkg.sv
  - vis_correlator.sv
  - vis_bank_ram.sv
  - vis_readback.sv
  - corr_block.sv
  - target: simulation
    files:
      - tb_corr_block.sv

// ==== tb_corr_block.sv ====
`timescale 1ns/1ps

module tb_corr_block import corr_pkg::*; ();

   localparam int          ACCUM       = ACCUM_DEF;
   localparam int          NANT        = NANT_DEF;
   localparam int          NPAIRS      = NPAIRS_DEF;
   localparam int          AW          = $clog2(NPAIRS) + 1;   // {pair, component}
   localparam int          PERIOD      = 8;                    // ns
   localparam int          RDY_TIMEOUT = 40;                   // Cycles
   localparam int unsigned SEED        = 32'hd5231286;

   logic                 sram_ck_i;
   logic                 rst_n_i;
   logic                 sw_i;
   logic                 en_i;
   logic [NANT-1:0]      re_i;
   logic [NANT-1:0]      im_i;
   logic                 sram_ce_i;
   logic [AW-1:0]        sram_ad_i;
   logic [ACCUM-1:0]     sram_do_o;
   logic                 vis_rdy_o;
   logic                 busy_o;

   // Reference sums, open period and last closed period
   logic [ACCUM-1:0] cur_re  [NPAIRS];
   logic [ACCUM-1:0] cur_im  [NPAIRS];
   logic [ACCUM-1:0] done_re [NPAIRS];
   logic [ACCUM-1:0] done_im [NPAIRS];

   corr_block dut_i (
      .sram_ck_i (sram_ck_i),
      .rst_n_i   (rst_n_i),
      .sw_i      (sw_i),
      .en_i      (en_i),
      .re_i      (re_i),
      .im_i      (im_i),
      .sram_ce_i (sram_ce_i),
      .sram_ad_i (sram_ad_i),
      .sram_do_o (sram_do_o),
      .vis_rdy_o (vis_rdy_o),
      .busy_o    (busy_o)
   );

   initial begin
      sram_ck_i = 1'b0;
      forever #(PERIOD/2) sram_ck_i = ~sram_ck_i;
   end

   // --------------------
   // Reference model
   // --------------------
   // Pair table (0,1) (2,3) (1,5) (6,4)
   function automatic int ant_a(input int p);
      case (p)
         0:       return 0;
         1:       return 2;
         2:       return 1;
         default: return 6;
      endcase
   endfunction

   function automatic int ant_b(input int p);
      case (p)
         0:       return 1;
         1:       return 3;
         2:       return 5;
         default: return 4;
      endcase
   endfunction

   // Like components agree
   function automatic int term_re(input int p, input logic [NANT-1:0] re,
                                  input logic [NANT-1:0] im);
      int n;
      n = 0;
      if (re[ant_a(p)] == re[ant_b(p)]) n++;
      if (im[ant_a(p)] == im[ant_b(p)]) n++;
      return n;
   endfunction

   // Cross terms, second one inverted
   function automatic int term_im(input int p, input logic [NANT-1:0] re,
                                  input logic [NANT-1:0] im);
      int n;
      n = 0;
      if (im[ant_a(p)] == re[ant_b(p)]) n++;
      if (re[ant_a(p)] != im[ant_b(p)]) n++;
      return n;
   endfunction

   // Expected bus word, LSB picks the component
   function automatic logic [ACCUM-1:0] exp_of(input int ad);
      return ad[0] ? done_im[ad/2] : done_re[ad/2];
   endfunction

   // --------------------
   // Drive helpers
   // --------------------
   task automatic check_val(input string name, input logic [31:0] exp_v,
                            input logic [31:0] act_v);
      if (act_v !== exp_v) begin
         $display("error: time %0t ns, %s expected 0x%0h, got 0x%0h",
                  $time, name, exp_v, act_v);
         $display("Result: FAILED");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   // Random sample onto the bus, model follows; newp closes the period
   task automatic apply_sample(input bit sw, input bit en, input bit newp);
      logic [NANT-1:0] re;
      logic [NANT-1:0] im;
      re   = NANT'($urandom);
      im   = NANT'($urandom);
      sw_i = sw;
      en_i = en;
      re_i = re;
      im_i = im;
      for (int p = 0; p < NPAIRS; p++) begin
         if (newp) begin
            done_re[p] = cur_re[p];                       // Closing values
            done_im[p] = cur_im[p];
            cur_re[p]  = en ? ACCUM'(term_re(p, re, im)) : '0;
            cur_im[p]  = en ? ACCUM'(term_im(p, re, im)) : '0;
         end else if (en) begin
            cur_re[p] = cur_re[p] + ACCUM'(term_re(p, re, im)); // Wraps
            cur_im[p] = cur_im[p] + ACCUM'(term_im(p, re, im));
         end
      end
   endtask

   task automatic drive_sample(input bit sw, input bit en, input bit newp);
      @(negedge sram_ck_i);
      apply_sample(sw, en, newp);
   endtask

   task automatic set_idle();
      sw_i = 1'b0;
      en_i = 1'b0;
   endtask

   // Samples keep coming during the dump, busy must stay up
   task automatic wait_rdy(input bit en, output int waited);
      int n;
      bit seen;
      n    = 0;
      seen = 1'b0;
      while (!seen) begin
         @(negedge sram_ck_i);
         n++;
         if (vis_rdy_o) begin
            seen = 1'b1;
            check_val("busy_o", 0, busy_o);    // Drops with the pulse
            set_idle();
         end else if (n > RDY_TIMEOUT) begin
            $display("error: the vis_rdy_o pulse never came within %0d cycles",
                     RDY_TIMEOUT);
            $display("Result: FAILED");
            $fatal(1, "ready pulse timeout");
         end else begin
            check_val("busy_o", 1, busy_o);
            apply_sample(1'b0, en, 1'b0);
         end
      end
      waited = n;
   endtask

   // Pulse is one cycle wide
   task automatic check_pulse_end();
      @(negedge sram_ck_i);
      check_val("vis_rdy_o", 0, vis_rdy_o);
   endtask

   // Strobe at R, data on the bus after R+2
   task automatic read_vis(input int ad, input logic [ACCUM-1:0] exp_v);
      @(negedge sram_ck_i);
      sram_ce_i = 1'b1;
      sram_ad_i = AW'(ad);
      @(negedge sram_ck_i);
      sram_ce_i = 1'b0;
      @(negedge sram_ck_i);
      check_val($sformatf("sram_do_o (addr %0d)", ad), exp_v, sram_do_o);
   endtask

   task automatic read_all();
      for (int ad = 0; ad < 2*NPAIRS; ad++) begin
         read_vis(ad, exp_of(ad));
      end
   endtask

   // --------------------
   // Directed tests
   // --------------------
   task automatic test_reset();
      @(negedge sram_ck_i);
      check_val("busy_o", 0, busy_o);
      check_val("vis_rdy_o", 0, vis_rdy_o);
      check_val("sram_do_o", 0, sram_do_o);
   endtask

   task automatic test_single_period();
      int waited;
      for (int i = 0; i < 24; i++) begin
         drive_sample(1'b0, 1'b1, 1'b0);
      end
      drive_sample(1'b1, 1'b1, 1'b1);
      wait_rdy(1'b1, waited);
      // Pulse set at T+NPAIRS+1, seen on the falling edge after it
      check_val("vis_rdy_o latency", NPAIRS + 2, waited);
      check_pulse_end();
      read_all();
   endtask

   task automatic test_enable_gating();
      int waited;
      for (int i = 0; i < 30; i++) begin
         drive_sample(1'b0, ($urandom % 2) == 0, 1'b0);
      end
      for (int i = 0; i < 10; i++) begin
         drive_sample(1'b0, 1'b0, 1'b0);              // Gated run
      end
      drive_sample(1'b1, 1'b0, 1'b1);
      wait_rdy(1'b0, waited);
      check_pulse_end();
      read_all();
   endtask

   task automatic test_bank_alternation();
      int waited;
      for (int i = 0; i < 16; i++) begin
         drive_sample(1'b0, 1'b1, 1'b0);
      end
      drive_sample(1'b1, 1'b1, 1'b1);       // This sample opens period two
      wait_rdy(1'b1, waited);
      check_pulse_end();
      read_all();
      for (int i = 0; i < 10; i++) begin
         drive_sample(1'b0, 1'b1, 1'b0);
      end
      drive_sample(1'b1, 1'b1, 1'b1);
      wait_rdy(1'b1, waited);
      check_pulse_end();
      read_all();                           // Second period only
   endtask

   task automatic test_switch_while_busy();
      int waited;
      for (int i = 0; i < 12; i++) begin
         drive_sample(1'b0, 1'b1, 1'b0);
      end
      drive_sample(1'b1, 1'b1, 1'b1);
      drive_sample(1'b0, 1'b1, 1'b0);
      @(negedge sram_ck_i);
      check_val("busy_o", 1, busy_o);
      apply_sample(1'b1, 1'b1, 1'b0);       // Ignored switch, plain sample
      wait_rdy(1'b1, waited);
      // No second dump may follow
      for (int i = 0; i < 3*(NPAIRS+2); i++) begin
         @(negedge sram_ck_i);
         check_val("vis_rdy_o", 0, vis_rdy_o);
         check_val("busy_o", 0, busy_o);
      end
      read_all();
   endtask

   task automatic test_read_latency_hold();
      logic [ACCUM-1:0] old_v;
      logic [ACCUM-1:0] new_v;
      int ad;
      read_vis(0, exp_of(0));
      old_v = exp_of(0);
      ad    = 0;
      // Look for a word that differs from the one on the bus
      for (int a = 1; a < 2*NPAIRS; a++) begin
         if (ad == 0 && exp_of(a) != old_v) begin
            ad = a;
         end
      end
      if (ad == 0) begin
         ad = 1;
      end
      new_v = exp_of(ad);
      @(negedge sram_ck_i);
      sram_ce_i = 1'b1;
      sram_ad_i = AW'(ad);
      @(negedge sram_ck_i);
      sram_ce_i = 1'b0;
      check_val("sram_do_o after one cycle", old_v, sram_do_o);
      @(negedge sram_ck_i);
      check_val("sram_do_o after two cycles", new_v, sram_do_o);
      for (int i = 0; i < 10; i++) begin
         sram_ad_i = AW'($urandom);         // Address moves, strobe low
         @(negedge sram_ck_i);
         check_val("sram_do_o held", new_v, sram_do_o);
      end
   endtask

   // --------------------
   // Main sequence
   // --------------------
   initial begin
      int unsigned seed_v;
      seed_v    = $urandom(SEED);
      rst_n_i   = 1'b0;
      sw_i      = 1'b0;
      en_i      = 1'b0;
      re_i      = '0;
      im_i      = '0;
      sram_ce_i = 1'b0;
      sram_ad_i = '0;
      for (int p = 0; p < NPAIRS; p++) begin
         cur_re[p]  = '0;
         cur_im[p]  = '0;
         done_re[p] = '0;
         done_im[p] = '0;
      end
      repeat (16) @(posedge sram_ck_i);
      @(negedge sram_ck_i);
      rst_n_i = 1'b1;

      test_reset();
      test_single_period();
      test_enable_gating();
      test_bank_alternation();
      test_switch_while_busy();
      test_read_latency_hold();

      $display("Result: PASSED");
      $finish;
   end

endmodule

// ==== corr_block.sv ====
`timescale 1ns/1ps

module corr_block import corr_pkg::*; #(
   parameter int                        ACCUM  = ACCUM_DEF,  // Accumulator width
   parameter int                        NANT   = NANT_DEF,   // Antennas on the bus
   parameter int                        NPAIRS = NPAIRS_DEF, // Power of two, at least 2
   parameter logic [PAIR_W*NPAIRS-1:0]  PAIRS  = PAIRS_DEF   // Pair table
) (
   input  logic                      sram_ck_i,
   input  logic                      rst_n_i,
   // Antenna samples
   input  logic                      sw_i,       // Bank switch strobe
   input  logic                      en_i,       // Samples valid
   input  logic [NANT-1:0]           re_i,
   input  logic [NANT-1:0]           im_i,
   // Read-back bus
   input  logic                      sram_ce_i,
   input  logic [$clog2(NPAIRS):0]   sram_ad_i,  // {pair, component}
   output logic [ACCUM-1:0]          sram_do_o,
   // Status
   output logic                      vis_rdy_o,  // Bank complete pulse
   output logic                      busy_o      // Dump running
);

   localparam int PW = $clog2(NPAIRS);
   localparam int AW = PW + 1;          // Bus address width
   localparam int WW = 2 * ACCUM;       // Memory word

   logic          wr_en;
   logic [PW-1:0] wr_pair;
   logic [WW-1:0] wr_data;
   logic          wr_bank;
   logic [WW-1:0] rd_data;
   logic          comp_sel;             // Address LSB
   logic [PW-1:0] rd_pair;              // Upper address bits

   // --------------------
   // Bus address split
   // --------------------
   assign comp_sel = sram_ad_i[0];
   assign rd_pair  = sram_ad_i[AW-1:1];

   // Producer, accumulates and dumps on switch
   vis_correlator #(
      .ACCUM  (ACCUM),
      .NANT   (NANT),
      .NPAIRS (NPAIRS),
      .PAIRS  (PAIRS)
   ) u_corr (
      .sram_ck_i (sram_ck_i),
      .rst_n_i   (rst_n_i),
      .sw_i      (sw_i),
      .en_i      (en_i),
      .re_i      (re_i),
      .im_i      (im_i),
      .wr_en_o   (wr_en),
      .wr_pair_o (wr_pair),
      .wr_data_o (wr_data),
      .wr_bank_o (wr_bank),
      .vis_rdy_o (vis_rdy_o),
      .busy_o    (busy_o)
   );

   // Two-bank visibility store
   vis_bank_ram #(
      .ACCUM  (ACCUM),
      .NPAIRS (NPAIRS)
   ) u_ram (
      .sram_ck_i (sram_ck_i),
      .wr_en_i   (wr_en),
      .wr_bank_i (wr_bank),
      .wr_pair_i (wr_pair),
      .wr_data_i (wr_data),
      .rd_en_i   (sram_ce_i),   // Strobe feeds both read stages
      .rd_pair_i (rd_pair),
      .rd_data_o (rd_data)
   );

   // Component mux onto the bus
   vis_readback #(
      .ACCUM (ACCUM)
   ) u_rdbk (
      .sram_ck_i (sram_ck_i),
      .rst_n_i   (rst_n_i),
      .ce_i      (sram_ce_i),
      .sel_i     (comp_sel),
      .rd_data_i (rd_data),
      .sram_do_o (sram_do_o)
   );

endmodule

// ==== vis_readback.sv ====
`timescale 1ns/1ps

module vis_readback import corr_pkg::*; #(
   parameter int ACCUM = ACCUM_DEF        // Component width
) (
   input  logic               sram_ck_i,
   input  logic               rst_n_i,
   input  logic               ce_i,       // Read strobe
   input  logic               sel_i,      // 0 real, 1 imaginary
   input  logic [2*ACCUM-1:0] rd_data_i,  // Word from the bank memory
   output logic [ACCUM-1:0]   sram_do_o   // Bus read data
);

   typedef logic [ACCUM-1:0] acc_t;

   logic ce_q;                            // Strobe, aligned to rd_data_i
   logic sel_q;                           // Component, aligned too
   acc_t comp_re;
   acc_t comp_im;
   acc_t comp_mux;

   // --------------------
   // Split the word
   // --------------------
   assign comp_re  = rd_data_i[2*ACCUM-1:ACCUM];   // Upper half
   assign comp_im  = rd_data_i[ACCUM-1:0];         // Lower half
   assign comp_mux = sel_q ? comp_im : comp_re;

   // --------------------
   // Output register
   // --------------------
   always_ff @(posedge sram_ck_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ce_q      <= 1'b0;
         sel_q     <= 1'b0;
         sram_do_o <= '0;
      end else begin
         // Memory takes one edge, so delay the controls by one
         ce_q  <= ce_i;
         sel_q <= sel_i;
         if (ce_q) begin
            sram_do_o <= comp_mux;   // Second stage of the read
         end
      end
   end

   // Without a strobe the bus keeps its last value
   // even while the address moves

endmodule

// ==== vis_bank_ram.sv ====
`timescale 1ns/1ps

module vis_bank_ram import corr_pkg::*; #(
   parameter int ACCUM  = ACCUM_DEF,    // Component width
   parameter int NPAIRS = NPAIRS_DEF    // Entries per bank
) (
   input  logic                      sram_ck_i,
   // Write side, from the correlator
   input  logic                      wr_en_i,
   input  logic                      wr_bank_i,   // Bank being filled
   input  logic [$clog2(NPAIRS)-1:0] wr_pair_i,
   input  logic [2*ACCUM-1:0]        wr_data_i,
   // Read side, from the bus
   input  logic                      rd_en_i,
   input  logic [$clog2(NPAIRS)-1:0] rd_pair_i,
   output logic [2*ACCUM-1:0]        rd_data_o    // Registered word
);

   localparam int PW    = $clog2(NPAIRS);
   localparam int WW    = 2 * ACCUM;
   localparam int DEPTH = 2 * NPAIRS;   // Both banks

   typedef logic [WW-1:0] vis_word_t;   // {re, im}
   typedef logic [PW:0]   ram_addr_t;   // {bank, pair}

   vis_word_t mem [DEPTH];

   ram_addr_t wr_addr;
   ram_addr_t rd_addr;

   // --------------------
   // Address map
   // --------------------
   // Bank bit on top, pair index below
   assign wr_addr = {wr_bank_i, wr_pair_i};
   // Bus always sees the bank that is not accumulating
   assign rd_addr = {~wr_bank_i, rd_pair_i};

   // --------------------
   // Write port
   // --------------------
   always_ff @(posedge sram_ck_i) begin
      if (wr_en_i) begin
         mem[wr_addr] <= wr_data_i;
      end
   end

   // --------------------
   // Read port
   // --------------------
   // One register stage, word held while idle
   always_ff @(posedge sram_ck_i) begin
      if (rd_en_i) begin
         rd_data_o <= mem[rd_addr];
      end
   end

   // Bank flip and last write never share an edge
   // so a read never lands in a half-written bank

endmodule

// ==== vis_correlator.sv ====
`timescale 1ns/1ps

module vis_correlator import corr_pkg::*; #(
   parameter int                        ACCUM  = ACCUM_DEF,  // Accumulator width
   parameter int                        NANT   = NANT_DEF,   // Sample bus width
   parameter int                        NPAIRS = NPAIRS_DEF, // Correlated pairs
   parameter logic [PAIR_W*NPAIRS-1:0]  PAIRS  = PAIRS_DEF   // Pair table
) (
   input  logic                         sram_ck_i,
   input  logic                         rst_n_i,
   // Antenna side
   input  logic                         sw_i,       // Close the period
   input  logic                         en_i,       // Samples valid
   input  logic [NANT-1:0]              re_i,       // Sign of real part
   input  logic [NANT-1:0]              im_i,       // Sign of imaginary part
   // Bank memory write port
   output logic                         wr_en_o,
   output logic [$clog2(NPAIRS)-1:0]    wr_pair_o,
   output logic [2*ACCUM-1:0]           wr_data_o,  // {re, im}
   output logic                         wr_bank_o,  // Bank now accumulating
   // Status
   output logic                         vis_rdy_o,  // Bank complete
   output logic                         busy_o      // Dump running
);

   localparam int PW = $clog2(NPAIRS);
   localparam int WW = 2 * ACCUM;

   typedef logic [ACCUM-1:0] acc_t;    // One visibility component

   dump_state_e   state_q;
   logic [PW-1:0] pair_q;              // Entry being written
   logic          busy_q;
   logic          flip_q;              // Last write done, flip next edge
   logic          rdy_q;
   logic          bank_q;
   logic          snap_go;             // Accepted bank switch
   logic [WW-1:0] vis_w [NPAIRS];      // Snapshot words, one per pair

   // Switch only counts while no dump is pending
   assign snap_go = sw_i && !busy_q;

   // --------------------
   // Per-pair accumulators
   // --------------------
   for (genvar k = 0; k < NPAIRS; k++) begin : g_pair
      // Unpack the table entry
      localparam ant_idx_t ANT_A = PAIRS[k*PAIR_W+ANT_W +: ANT_W];
      localparam ant_idx_t ANT_B = PAIRS[k*PAIR_W +: ANT_W];

      logic [1:0] re_inc;              // 0, 1 or 2 per sample
      logic [1:0] im_inc;
      acc_t       acc_re;
      acc_t       acc_im;
      acc_t       snap_re;             // Value at the switch
      acc_t       snap_im;

      // Real part counts agreements of like components
      assign re_inc = {1'b0, re_i[ANT_A] ~^ re_i[ANT_B]}
                    + {1'b0, im_i[ANT_A] ~^ im_i[ANT_B]};
      // Imaginary part, cross terms with one sign flipped
      assign im_inc = {1'b0, im_i[ANT_A] ~^ re_i[ANT_B]}
                    + {1'b0, re_i[ANT_A] ^ im_i[ANT_B]};

      always_ff @(posedge sram_ck_i or negedge rst_n_i) begin
         if (!rst_n_i) begin
            acc_re <= '0;
            acc_im <= '0;
         end else if (snap_go) begin
            // Sample at the switch opens the new period
            acc_re <= en_i ? acc_t'(re_inc) : '0;
            acc_im <= en_i ? acc_t'(im_inc) : '0;
         end else if (en_i) begin
            acc_re <= acc_re + acc_t'(re_inc);   // Wraps mod 2**ACCUM
            acc_im <= acc_im + acc_t'(im_inc);
         end
      end

      // Closing values held for the dump
      always_ff @(posedge sram_ck_i) begin
         if (snap_go) begin
            snap_re <= acc_re;
            snap_im <= acc_im;
         end
      end

      assign vis_w[k] = {snap_re, snap_im};    // Real in upper half
   end

   // --------------------
   // Dump sequencer
   // --------------------
   always_ff @(posedge sram_ck_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= DUMP_IDLE;
         pair_q  <= '0;
         busy_q  <= 1'b0;
         flip_q  <= 1'b0;
         rdy_q   <= 1'b0;
         bank_q  <= 1'b0;
      end else begin
         flip_q <= 1'b0;               // Both are single-cycle
         rdy_q  <= 1'b0;
         case (state_q)
            DUMP_IDLE: begin
               if (snap_go) begin
                  state_q <= DUMP_WRITE;
                  pair_q  <= '0;
                  busy_q  <= 1'b1;
               end
            end
            DUMP_WRITE: begin
               pair_q <= pair_q + 1'b1;   // Wraps back to 0 after the last
               if (pair_q == PW'(NPAIRS - 1)) begin
                  state_q <= DUMP_IDLE;
                  flip_q  <= 1'b1;
               end
            end
            default: state_q <= DUMP_IDLE;
         endcase
         // One cycle after the last write, hand the bank over
         if (flip_q) begin
            bank_q <= ~bank_q;
            rdy_q  <= 1'b1;
            busy_q <= 1'b0;
         end
      end
   end

   // Write port, one entry per cycle in WRITE
   assign wr_en_o   = (state_q == DUMP_WRITE);
   assign wr_pair_o = pair_q;
   assign wr_data_o = vis_w[pair_q];
   assign wr_bank_o = bank_q;

   assign vis_rdy_o = rdy_q;
   assign busy_o    = busy_q;

endmodule

// ==== corr_pkg.sv ====
package corr_pkg;

   // --------------------
   // Antenna pair encoding
   // --------------------
   localparam int ANT_W  = 3;           // Antenna index bits, up to 8 antennas
   localparam int PAIR_W = 2 * ANT_W;   // One table entry, {a, b}

   typedef logic [ANT_W-1:0] ant_idx_t; // Antenna index

   // --------------------
   // Default block setup
   // --------------------
   localparam int ACCUM_DEF  = 16;      // Accumulator width
   localparam int NANT_DEF   = 8;       // Antennas on the sample bus
   localparam int NPAIRS_DEF = 4;       // Pairs per block, power of two

   // Entry k sits at bits [PAIR_W*k +: PAIR_W]
   // Antenna a in the upper three bits, antenna b in the lower three
   localparam logic [PAIR_W*NPAIRS_DEF-1:0] PAIRS_DEF = {
      6'o64,   // Pair 3: (6,4)
      6'o15,   // Pair 2: (1,5)
      6'o23,   // Pair 1: (2,3)
      6'o01    // Pair 0: (0,1)
   };

   // --------------------
   // Dump sequencer
   // --------------------
   // Idle while accumulating, write while copying snapshots into the bank
   typedef enum logic {
      DUMP_IDLE  = 1'b0,   // Waiting for a bank switch
      DUMP_WRITE = 1'b1    // One snapshot per cycle to the memory
   } dump_state_e;

   // Derived widths are worked out in each module
   //   pair index   : log2 of the pair count
   //   bus address  : pair index plus component bit
   //   memory word  : real and imaginary side by side

endpackage
